// ==== pzx_pkg.sv ====
`default_nettype none

package pzx_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    typedef logic [20:0] sram_addr_t;    // One SRAM word address
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] block_len_t;    // Bytes left in current block
    typedef logic [30:0] duration_t;     // In CPU T-states
    typedef logic [15:0] pulse_count_t;

    // Host register numbers
    localparam byte_t REG_SRAM_DATA     = 8'hfd;
    localparam byte_t REG_SRAM_ADDR_INC = 8'hfc;
    localparam byte_t REG_SRAM_ADDR     = 8'hfb;

    // PZX block tags handled by the player
    typedef enum logic [7:0] {
        TAG_FULLSTOP = 8'd0,
        TAG_STOP     = 8'd1,
        TAG_PULSE    = 8'd2,
        TAG_PAUSE    = 8'd4
    } pzx_tag_e;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_READ_TAG,
        ST_READ_LEN,
        ST_STOP,
        ST_FULLSTOP,
        ST_PAUSE_READ,
        ST_PAUSE_WAIT,
        ST_PULSE_ENTRY,      // Low byte of first word, or end of block
        ST_PULSE_W0_HI,
        ST_PULSE_CHK_REP,
        ST_PULSE_REP_HI,
        ST_PULSE_CHK_LONG,
        ST_PULSE_LONG_HI,
        ST_PULSE_GO,
        ST_PULSE_RUN
    } player_state_e;

    // ------------------------------------------------------------
    // Bus bundles
    // ------------------------------------------------------------
    typedef struct packed {
        byte_t reg_addr;
        logic  rd;
        logic  wr;
        byte_t wdata;
    } host_bus_t;

    typedef struct packed {
        sram_addr_t addr;
        logic       we_n;
        byte_t      wdata;
    } mem_bus_t;

endpackage

`default_nettype wire

// ==== sram_host_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_host_port
    import pzx_pkg::*;
(
    input  wire       clk,
    input  wire       rst_n,
    input  host_bus_t host,
    input  wire       player_idle,
    output logic      mem_we_n,
    output logic      oe_n,
    output logic      addr_shift,
    output logic      addr_inc,
    output logic      host_busy
);

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_PROGRESS,
        HS_INC
    } host_state_e;

    host_state_e state;
    logic        data_sel;
    logic        addr_sel;
    logic        strobe;
    logic        accept;
    logic        inc_pending;

    // Both data ports reach the SRAM
    assign data_sel = (host.reg_addr == REG_SRAM_DATA) || (host.reg_addr == REG_SRAM_ADDR_INC);
    assign addr_sel = (host.reg_addr == REG_SRAM_ADDR);
    assign strobe   = host.rd || host.wr;

    assign mem_we_n = !(data_sel && host.wr);
    assign oe_n     = !(data_sel && host.rd);

    assign accept = (state == HS_IDLE) && player_idle &&
                    ((data_sel && strobe) || (addr_sel && host.wr));

    assign addr_shift = accept && addr_sel;   // Next address byte shifts in
    assign addr_inc   = (state == HS_INC);
    assign host_busy  = accept || (state != HS_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= HS_IDLE;
            inc_pending <= 1'b0;
        end else begin
            case (state)
                HS_IDLE: begin
                    if (accept) begin
                        inc_pending <= (host.reg_addr == REG_SRAM_ADDR_INC);
                        state       <= HS_PROGRESS;
                    end
                end
                HS_PROGRESS: begin
                    // Wait for the host to drop both strobes
                    if (!strobe) begin
                        state <= inc_pending ? HS_INC : HS_IDLE;
                    end
                end
                HS_INC: state <= HS_IDLE;
                default: state <= HS_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tape_addr_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tape_addr_counter
    import pzx_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  byte_t      shift_byte,
    input  wire        shift,
    input  wire        inc,
    input  wire        clear,
    output sram_addr_t addr
);

    sram_addr_t addr_q;

    assign addr = addr_q;

    // Clear beats shift, shift beats increment
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (clear) begin
            addr_q <= '0;
        end else if (shift) begin
            addr_q <= {addr_q[12:0], shift_byte};   // Top byte falls off
        end else if (inc) begin
            addr_q <= addr_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== tstate_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tstate_timer
    import pzx_pkg::*;
#(
    parameter int TSTATE_SHIFT = 3
) (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       start,
    input  duration_t duration,
    output logic      done
);

    localparam int CNT_W = $bits(duration_t) + TSTATE_SHIFT;

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] limit;
    duration_t        duration_q;
    logic             armed;

    // Duration in clock cycles
    assign limit = CNT_W'(duration_q) << TSTATE_SHIFT;
    assign done  = armed && (count == limit);   // Held until next start

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            armed <= 1'b0;
            count <= '0;
        end else if (start) begin
            armed <= 1'b1;
            count <= '0;
        end else if (armed && !done) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            duration_q <= duration;
        end
    end

endmodule

`default_nettype wire

// ==== pzx_block_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module pzx_block_fsm
    import pzx_pkg::*;
(
    input  wire       clk,
    input  wire       rst_n,
    input  wire       play_in,
    input  wire       stop_in,
    input  byte_t     rdata,
    input  wire       host_busy,
    output logic      addr_inc,
    output logic      addr_clear,
    output logic      timer_start,
    output duration_t timer_duration,
    input  wire       timer_done,
    output logic      player_idle,
    output logic      pulse_out,
    output logic      playing
);

    player_state_e state;
    logic [1:0]    play_sr;
    logic [1:0]    stop_sr;
    logic          play_edge;
    logic          stop_edge;
    logic          run;
    logic          playing_q;
    logic          pulse_q;
    logic          len_dec;
    logic          rep_form;
    logic          dur_zero;
    logic [1:0]    byte_idx;
    byte_t         tag;
    block_len_t    block_len;
    logic [23:0]   pause_lo;    // Low three bytes of a pause duration
    pulse_count_t  pulse_cnt;
    duration_t     pulse_dur;

    assign play_edge = (play_sr == 2'b01);
    assign stop_edge = (stop_sr == 2'b01);
    assign run       = playing_q && !play_edge && !stop_edge;

    assign rep_form = (pulse_dur[15:0] > 16'h8000);   // First word was a repeat count
    assign dur_zero = (pulse_dur == '0);

    assign player_idle = (state == ST_IDLE);
    assign pulse_out   = pulse_q;
    assign playing     = playing_q;

    // Top bit of the last pause byte is the level, not duration
    assign timer_duration = (state == ST_PAUSE_READ) ? {rdata[6:0], pause_lo} : pulse_dur;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            play_sr <= '0;
            stop_sr <= '0;
        end else begin
            play_sr <= {play_sr[0], play_in};
            stop_sr <= {stop_sr[0], stop_in};
        end
    end

    // ------------------------------------------------------------
    // Byte consumption and timer requests
    // ------------------------------------------------------------
    always_comb begin
        addr_inc    = 1'b0;
        len_dec     = 1'b0;
        timer_start = 1'b0;
        addr_clear  = stop_edge && !play_edge;
        if (state == ST_IDLE) begin
            addr_clear = addr_clear || (run && !host_busy);   // Rewind on play
        end else if (run) begin
            case (state)
                ST_READ_TAG,
                ST_READ_LEN: addr_inc = 1'b1;
                ST_FULLSTOP: addr_clear = 1'b1;
                ST_PAUSE_READ: begin
                    addr_inc    = 1'b1;
                    timer_start = (byte_idx == 2'd3);
                end
                ST_PULSE_ENTRY:    addr_inc = (block_len != '0);
                ST_PULSE_CHK_REP:  addr_inc = rep_form;
                ST_PULSE_CHK_LONG: addr_inc = pulse_dur[15];
                ST_PULSE_W0_HI,
                ST_PULSE_REP_HI,
                ST_PULSE_LONG_HI:  addr_inc = 1'b1;
                ST_PULSE_GO:  timer_start = !dur_zero;
                ST_PULSE_RUN: timer_start = timer_done && (pulse_cnt != 16'd1);
                default: ;
            endcase
            if (state >= ST_PULSE_ENTRY && state <= ST_PULSE_LONG_HI) begin
                len_dec = addr_inc;
            end
        end
    end

    // ------------------------------------------------------------
    // Block parser
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            playing_q <= 1'b0;
            pulse_q   <= 1'b0;
            byte_idx  <= '0;
        end else if (play_edge) begin
            playing_q <= !playing_q;
        end else if (stop_edge) begin
            playing_q <= 1'b0;
            state     <= ST_IDLE;
        end else if (state == ST_IDLE) begin
            if (playing_q && !host_busy) begin
                pulse_q <= 1'b0;
                state   <= ST_READ_TAG;
            end
        end else if (playing_q) begin
            if (len_dec) begin
                block_len <= block_len - 1'b1;
            end
            case (state)
                ST_READ_TAG: begin
                    tag      <= rdata;
                    byte_idx <= '0;
                    state    <= ST_READ_LEN;
                end
                ST_READ_LEN: begin
                    block_len <= {rdata, block_len[31:8]};   // LSB first
                    byte_idx  <= byte_idx + 1'b1;
                    if (byte_idx == 2'd3) begin
                        case (tag)
                            TAG_STOP:  state <= ST_STOP;
                            TAG_PAUSE: state <= ST_PAUSE_READ;
                            TAG_PULSE: begin
                                pulse_q <= 1'b0;
                                state   <= ST_PULSE_ENTRY;
                            end
                            default:   state <= ST_FULLSTOP;
                        endcase
                    end
                end
                ST_STOP: begin
                    playing_q <= 1'b0;
                    state     <= ST_READ_TAG;   // Resume at the next block
                end
                ST_FULLSTOP: begin
                    playing_q <= 1'b0;
                    state     <= ST_IDLE;
                end
                ST_PAUSE_READ: begin
                    pause_lo <= {rdata, pause_lo[23:8]};
                    byte_idx <= byte_idx + 1'b1;
                    if (byte_idx == 2'd3) begin
                        pulse_q <= rdata[7];
                        state   <= ST_PAUSE_WAIT;
                    end
                end
                ST_PAUSE_WAIT: begin
                    if (timer_done) begin
                        state <= ST_READ_TAG;
                    end
                end
                ST_PULSE_ENTRY: begin
                    if (addr_inc) begin
                        pulse_cnt <= 16'd1;
                        pulse_dur <= {23'd0, rdata};
                        state     <= ST_PULSE_W0_HI;
                    end else begin
                        state <= ST_READ_TAG;
                    end
                end
                ST_PULSE_W0_HI: begin
                    pulse_dur[15:8] <= rdata;
                    state           <= ST_PULSE_CHK_REP;
                end
                ST_PULSE_CHK_REP: begin
                    if (rep_form) begin
                        pulse_cnt      <= {1'b0, pulse_dur[14:0]};
                        pulse_dur[7:0] <= rdata;
                        state          <= ST_PULSE_REP_HI;
                    end else begin
                        state <= ST_PULSE_CHK_LONG;
                    end
                end
                ST_PULSE_REP_HI: begin
                    pulse_dur[15:8] <= rdata;
                    state           <= ST_PULSE_CHK_LONG;
                end
                ST_PULSE_CHK_LONG: begin
                    if (pulse_dur[15]) begin
                        pulse_dur[30:16] <= pulse_dur[14:0];   // Upper half of a long duration
                        pulse_dur[7:0]   <= rdata;
                        state            <= ST_PULSE_LONG_HI;
                    end else begin
                        state <= ST_PULSE_GO;
                    end
                end
                ST_PULSE_LONG_HI: begin
                    pulse_dur[15:8] <= rdata;
                    state           <= ST_PULSE_GO;
                end
                ST_PULSE_GO: begin
                    if (dur_zero) begin
                        pulse_q <= pulse_cnt[0];
                        state   <= ST_PULSE_ENTRY;
                    end else begin
                        state <= ST_PULSE_RUN;
                    end
                end
                ST_PULSE_RUN: begin
                    if (timer_done) begin
                        pulse_q <= !pulse_q;
                        if (pulse_cnt == 16'd1) begin
                            state <= ST_PULSE_ENTRY;
                        end else begin
                            pulse_cnt <= pulse_cnt - 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== pzx_player.sv ====
`timescale 1ns/1ps
`default_nettype none

module pzx_player
    import pzx_pkg::*;
#(
    parameter int TSTATE_SHIFT = 3   // 8 clocks per T-state
) (
    input  wire       clk,
    input  wire       rst_n,
    input  host_bus_t host,
    output byte_t     dout,
    output logic      oe_n,
    input  wire       play_in,
    input  wire       stop_in,
    output logic      pulse_out,
    output logic      playing,
    output mem_bus_t  mem,
    input  byte_t     mem_rdata
);

    sram_addr_t sram_addr;
    duration_t  timer_duration;
    logic       mem_we_n;
    logic       addr_shift;
    logic       host_inc;
    logic       player_inc;
    logic       addr_clear;
    logic       host_busy;
    logic       player_idle;
    logic       timer_start;
    logic       timer_done;

    assign mem  = '{addr: sram_addr, we_n: mem_we_n, wdata: host.wdata};
    assign dout = mem_rdata;

    // ------------------------------------------------------------
    // Host side
    // ------------------------------------------------------------
    sram_host_port sram_host_port_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .host        (host),
        .player_idle (player_idle),
        .mem_we_n    (mem_we_n),
        .oe_n        (oe_n),
        .addr_shift  (addr_shift),
        .addr_inc    (host_inc),
        .host_busy   (host_busy)
    );

    tape_addr_counter tape_addr_counter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .shift_byte (host.wdata),
        .shift      (addr_shift),
        .inc        (host_inc || player_inc),
        .clear      (addr_clear),
        .addr       (sram_addr)
    );

    // ------------------------------------------------------------
    // Player side
    // ------------------------------------------------------------
    tstate_timer #(
        .TSTATE_SHIFT (TSTATE_SHIFT)
    ) tstate_timer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (timer_start),
        .duration (timer_duration),
        .done     (timer_done)
    );

    pzx_block_fsm pzx_block_fsm_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .play_in        (play_in),
        .stop_in        (stop_in),
        .rdata          (mem_rdata),
        .host_busy      (host_busy),
        .addr_inc       (player_inc),
        .addr_clear     (addr_clear),
        .timer_start    (timer_start),
        .timer_duration (timer_duration),
        .timer_done     (timer_done),
        .player_idle    (player_idle),
        .pulse_out      (pulse_out),
        .playing        (playing)
    );

endmodule

`default_nettype wire

// ==== tb_pzx_player.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pzx_player
    import pzx_pkg::*;
;

    typedef struct packed {
        byte_t        tag;
        duration_t    dur;
        pulse_count_t count;
        logic         level;       // Expected pulse_out after the block
        logic         long_form;   // Duration sent as two words
    } block_row_t;

    logic       clk;
    logic       rst_n;
    host_bus_t  host;
    byte_t      dout;
    logic       oe_n;
    logic       play_in;
    logic       stop_in;
    logic       pulse_out;
    logic       playing;
    mem_bus_t   mem;
    byte_t      mem_rdata;
    byte_t      sram [0:(1<<21)-1];
    block_row_t rows [0:6];
    byte_t      image [$];
    logic [31:0] seed;

    pzx_player #(
        .TSTATE_SHIFT (3)
    ) pzx_player_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .host      (host),
        .dout      (dout),
        .oe_n      (oe_n),
        .play_in   (play_in),
        .stop_in   (stop_in),
        .pulse_out (pulse_out),
        .playing   (playing),
        .mem       (mem),
        .mem_rdata (mem_rdata)
    );

    initial clk = 1'b0;
    always #50 clk = !clk;

    // SRAM model
    always @(posedge clk) begin
        if (!mem.we_n) sram[mem.addr] <= mem.wdata;
    end
    assign mem_rdata = sram[mem.addr];

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic duration_t rand_dur();
        seed = xorshift(seed);
        return duration_t'(2 + seed[3:0]);   // Short durations of 2 to 17 T-states
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp));
        end
    endtask

    task automatic put_le(input logic [31:0] v, input int n);
        for (int i = 0; i < n; i++) image.push_back(v[8*i +: 8]);   // LSB first
    endtask

    task automatic host_access(input byte_t reg_addr, input logic rd, input logic wr,
                               input byte_t wdata, output byte_t rdata);
        logic data_port;
        data_port = (reg_addr != REG_SRAM_ADDR);
        @(posedge clk);
        #1;
        host = '{reg_addr: reg_addr, rd: rd, wr: wr, wdata: wdata};
        @(negedge clk);
        rdata = dout;
        check("oe_n", oe_n, !(rd && data_port));
        check("mem.we_n", mem.we_n, !(wr && data_port));
        @(posedge clk);
        #1;
        host.rd = 1'b0;
        host.wr = 1'b0;
        repeat (3) @(posedge clk);   // Host port returns to idle
    endtask

    task automatic set_addr(input sram_addr_t a);
        byte_t unused;
        host_access(REG_SRAM_ADDR, 1'b0, 1'b1, {3'b0, a[20:16]}, unused);
        host_access(REG_SRAM_ADDR, 1'b0, 1'b1, a[15:8], unused);
        host_access(REG_SRAM_ADDR, 1'b0, 1'b1, a[7:0], unused);
    endtask

    task automatic press(input logic is_stop);
        @(posedge clk);
        #1;
        if (is_stop) stop_in = 1'b1;
        else play_in = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        stop_in = 1'b0;
        play_in = 1'b0;
    endtask

    // Cycles until pulse_out changes
    task automatic wait_toggle(output int n);
        logic prev;
        prev = pulse_out;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 1000) fail_run("Timeout waiting for a pulse_out toggle");
        end while (pulse_out == prev);
    endtask

    task automatic wait_playing(input logic v);
        int n;
        n = 0;
        while (playing !== v) begin
            @(negedge clk);
            n++;
            if (n > 1000) fail_run("Timeout waiting for playing to change");
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        byte_t rd;
        int    n;
        host    = '0;
        play_in = 1'b0;
        stop_in = 1'b0;
        rst_n   = 1'b0;
        seed    = 32'ha76f_7dce;

        rows[0] = '{TAG_PULSE, rand_dur(), 16'd4, 1'b0, 1'b0};
        rows[1] = '{TAG_PULSE, rand_dur(), 16'd2, 1'b0, 1'b1};
        rows[2] = '{TAG_PULSE, rand_dur(), 16'd6, 1'b0, 1'b0};
        rows[3] = '{TAG_PULSE, 31'd0, 16'd3, 1'b1, 1'b0};   // Zero duration sets level only
        rows[4] = '{TAG_PAUSE, rand_dur(), 16'd0, 1'b0, 1'b0};
        rows[5] = '{TAG_PAUSE, rand_dur(), 16'd0, 1'b1, 1'b0};
        rows[6] = '{TAG_STOP, 31'd0, 16'd0, 1'b1, 1'b0};

        foreach (rows[r]) begin
            image.push_back(rows[r].tag);
            case (rows[r].tag)
                TAG_PULSE: begin
                    put_le(rows[r].long_form ? 6 : 4, 4);
                    put_le({16'd0, 16'h8000 | rows[r].count}, 2);
                    if (rows[r].long_form) put_le({16'd0, 1'b1, rows[r].dur[30:16]}, 2);
                    put_le({16'd0, rows[r].dur[15:0]}, 2);
                end
                TAG_PAUSE: begin
                    put_le(4, 4);
                    put_le({rows[r].level, rows[r].dur}, 4);
                end
                default: put_le(0, 4);
            endcase
        end

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check("pulse_out", pulse_out, 0);
        check("playing", playing, 0);
        check("mem.we_n", mem.we_n, 1);
        check("oe_n", oe_n, 1);

        // Host access
        set_addr(21'h12_3456);
        check("mem.addr", mem.addr, 21'h12_3456);
        set_addr(21'h0);
        foreach (image[i]) host_access(REG_SRAM_ADDR_INC, 1'b0, 1'b1, image[i], rd);
        set_addr(21'h0);
        foreach (image[i]) begin
            host_access(REG_SRAM_ADDR_INC, 1'b1, 1'b0, 8'h00, rd);
            check("dout", rd, image[i]);
        end

        // Playback of the whole table
        press(1'b0);
        foreach (rows[r]) begin
            case (rows[r].tag)
                TAG_PULSE: begin
                    if (rows[r].dur == 0) begin
                        if (rows[r].count[0]) wait_toggle(n);
                    end else begin
                        wait_toggle(n);   // First level follows a parse gap
                        for (int k = 1; k < rows[r].count; k++) begin
                            wait_toggle(n);
                            check("pulse interval", n, 8 * rows[r].dur + 1);
                        end
                    end
                    check("pulse_out", pulse_out, rows[r].level);
                end
                TAG_PAUSE: begin
                    wait_toggle(n);
                    check("pulse_out", pulse_out, rows[r].level);
                    repeat (8 * rows[r].dur) begin
                        @(negedge clk);
                        check("pulse_out", pulse_out, rows[r].level);
                    end
                end
                default: begin
                    wait_playing(1'b0);
                    check("mem.addr", mem.addr, image.size());
                end
            endcase
        end

        press(1'b1);
        @(negedge clk);
        check("mem.addr", mem.addr, 0);

        // stop_in in the middle of a train
        press(1'b0);
        wait_toggle(n);   // Level drops as playback restarts
        wait_toggle(n);   // First pulse of the opening train
        press(1'b1);
        wait_playing(1'b0);
        @(negedge clk);
        check("mem.addr", mem.addr, 0);

        // Unknown tag
        set_addr(21'h0);
        foreach (image[i]) begin
            if (i < 5) host_access(REG_SRAM_ADDR_INC, 1'b0, 1'b1, (i == 0) ? 8'h30 : 8'h00, rd);
        end
        press(1'b0);
        wait_playing(1'b1);
        wait_playing(1'b0);
        @(negedge clk);
        check("mem.addr", mem.addr, 0);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== pzx_player.f ====
pzx_pkg.sv
sram_host_port.sv
tape_addr_counter.sv
tstate_timer.sv
pzx_block_fsm.sv
pzx_player.sv
tb_pzx_player.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PZX player testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_pzx_player \
    -f pzx_player.f -o sim_pzx_player > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_pzx_player > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "Simulation did not finish"; exit 1; }
